// File: dv/noc_clk_gen.sv
`timescale 1ns/1ps

module noc_clk_gen #(
  parameter real PERIOD_NS = 10.0
)(
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always #(PERIOD_NS / 2.0) o_clk = ~o_clk; // free running.

endmodule

// File: dv/noc_subsys_chk.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_subsys_chk (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic [1:0]                    i_req_valid,
  input  logic [1:0]                    i_req_write,
  input  logic [1:0][`NOC_ADDR_W-1:0]   i_req_addr,
  input  logic [1:0][`NOC_DATA_W-1:0]   i_req_wdata,
  input  logic [1:0]                    i_req_ready,
  input  logic [1:0]                    i_rsp_valid,
  input  logic [1:0][`NOC_DATA_W-1:0]   i_rsp_rdata,
  input  logic [1:0][1:0]               i_rsp_code
);
  import noc_access_pkg::*;

  localparam int WORD_W = $clog2(`NOC_MEM_DEPTH);
  localparam int IDX_W  = WORD_W + 1; // target select above the word index.

  logic [`NOC_DATA_W-1:0]      shadow [2*`NOC_MEM_DEPTH];
  logic [2*`NOC_MEM_DEPTH-1:0] shadow_vld;
  logic [1:0]                  accept;
  logic [1:0]                  pend;
  logic [1:0]                  pend_wr;
  logic [1:0]                  pend_unmapped;
  logic [1:0][IDX_W-1:0]       pend_idx;
  logic [1:0][`NOC_DATA_W-1:0] pend_wdata;
  int unsigned                 err_count = 0; // failed assertions so far.

  assign accept = i_req_valid & i_req_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend       <= '0;
      shadow_vld <= '0;
    end else begin
      for (int n = 0; n < 2; n++) begin
        if (accept[n]) begin
          pend[n] <= 1'b1;
        end else if (i_rsp_valid[n]) begin
          pend[n] <= 1'b0;
        end
        // a target serves one packet at a time, so write completions follow memory order.
        if (i_rsp_valid[n] && pend_wr[n] && !pend_unmapped[n]) begin
          shadow[pend_idx[n]]     <= pend_wdata[n];
          shadow_vld[pend_idx[n]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int n = 0; n < 2; n++) begin
      if (accept[n]) begin
        pend_wr[n]       <= i_req_write[n];
        pend_unmapped[n] <= i_req_addr[n][`NOC_ADDR_W-1]; // regions 2 and 3.
        pend_idx[n]      <= {i_req_addr[n][`NOC_ADDR_W-2], i_req_addr[n][WORD_W+1:2]};
        pend_wdata[n]    <= i_req_wdata[n];
      end
    end
  end

  for (genvar n = 0; n < 2; n++) begin : g_init
    logic [1:0]             exp_code;
    logic [`NOC_DATA_W-1:0] exp_rdata;
    logic                   rdata_known;

    assign exp_code    = pend_unmapped[n] ? DECERR : OKAY;
    assign exp_rdata   = pend_unmapped[n] ? '0 : shadow[pend_idx[n]];
    assign rdata_known = pend_unmapped[n] || (!pend_wr[n] && shadow_vld[pend_idx[n]]);

    a_rsp_in_flight: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rsp_valid[n] |-> pend[n])
      else begin
        err_count++;
        $error("initiator %0d gave a response with no request in flight", n);
      end

    a_decerr_next: assert property (@(posedge i_clk) disable iff (i_rst)
      accept[n] && i_req_addr[n][`NOC_ADDR_W-1] |=> i_rsp_valid[n])
      else begin
        err_count++;
        $error("initiator %0d did not answer an unmapped address one cycle after it", n);
      end

    a_rsp_code: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rsp_valid[n] |-> i_rsp_code[n] == exp_code)
      else begin
        err_count++;
        $error("Mismatch at %0t: o_rsp%0d_code got %0d expected %0d", $time, n,
               $sampled(i_rsp_code[n]), $sampled(exp_code));
      end

    a_rsp_rdata: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rsp_valid[n] && rdata_known |-> i_rsp_rdata[n] == exp_rdata)
      else begin
        err_count++;
        $error("Mismatch at %0t: o_rsp%0d_rdata got %h expected %h", $time, n,
               $sampled(i_rsp_rdata[n]), $sampled(exp_rdata));
      end
  end

endmodule

bind noc_subsys_top noc_subsys_chk u_chk (
  .i_clk       (i_clk                         ),
  .i_rst       (i_rst                         ),
  .i_req_valid ({i_req1_valid, i_req0_valid}  ),
  .i_req_write ({i_req1_write, i_req0_write}  ),
  .i_req_addr  ({i_req1_addr, i_req0_addr}    ),
  .i_req_wdata ({i_req1_wdata, i_req0_wdata}  ),
  .i_req_ready ({o_req1_ready, o_req0_ready}  ),
  .i_rsp_valid ({o_rsp1_valid, o_rsp0_valid}  ),
  .i_rsp_rdata ({o_rsp1_rdata, o_rsp0_rdata}  ),
  .i_rsp_code  ({o_rsp1_code, o_rsp0_code}    )
);

// File: dv/noc_subsys_tb.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_subsys_tb;
  import noc_access_pkg::*;

  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;
  localparam int RSP_LIMIT       = 50; // cycles from acceptance to response.
  localparam int RAND_OPS        = 12;

  logic                        clk;
  logic                        rst;
  logic [1:0]                  req_valid;
  logic [1:0]                  req_write;
  logic [1:0][`NOC_ADDR_W-1:0] req_addr;
  logic [1:0][`NOC_DATA_W-1:0] req_wdata;
  logic [1:0]                  req_ready;
  logic [1:0]                  rsp_valid;
  logic [1:0][`NOC_DATA_W-1:0] rsp_rdata;
  noc_resp_e                   rsp_code [2];

  integer                 seed;
  int                     errors;
  int                     test_base;
  int                     pass_cnt;
  int                     fail_cnt;
  logic [`NOC_DATA_W-1:0] exp_tgt0 [4];
  logic [`NOC_DATA_W-1:0] exp_tgt1 [4];
  logic                   rnd_wr   [2][RAND_OPS];
  logic [`NOC_ADDR_W-1:0] rnd_addr [2][RAND_OPS];
  logic [`NOC_DATA_W-1:0] rnd_data [2][RAND_OPS];

  noc_clk_gen #(.PERIOD_NS(10.0)) u_clk_gen (.o_clk(clk));

  noc_subsys_top u_noc_subsys_top (
    .i_clk        (clk          ),
    .i_rst        (rst          ),
    .i_req0_valid (req_valid[0] ),
    .i_req0_write (req_write[0] ),
    .i_req0_addr  (req_addr[0]  ),
    .i_req0_wdata (req_wdata[0] ),
    .o_req0_ready (req_ready[0] ),
    .o_rsp0_valid (rsp_valid[0] ),
    .o_rsp0_rdata (rsp_rdata[0] ),
    .o_rsp0_code  (rsp_code[0]  ),
    .i_req1_valid (req_valid[1] ),
    .i_req1_write (req_write[1] ),
    .i_req1_addr  (req_addr[1]  ),
    .i_req1_wdata (req_wdata[1] ),
    .o_req1_ready (req_ready[1] ),
    .o_rsp1_valid (rsp_valid[1] ),
    .o_rsp1_rdata (rsp_rdata[1] ),
    .o_rsp1_code  (rsp_code[1]  )
  );

  // region in [15:14], word index in [9:2].
  function automatic logic [`NOC_ADDR_W-1:0] word_addr(input logic [1:0] region,
                                                       input logic [7:0] idx);
    return {region, 4'b0000, idx, 2'b00};
  endfunction

  function automatic int total_errors();
    return errors + u_noc_subsys_top.u_chk.err_count;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // one request on initiator n, back when its response pulse is seen.
  task automatic do_access(input int n, input logic wr, input logic [`NOC_ADDR_W-1:0] addr,
                           input logic [`NOC_DATA_W-1:0] wdata,
                           output logic [`NOC_DATA_W-1:0] rdata, output noc_resp_e code,
                           output int lat);
    lat   = 0;
    rdata = '0;
    code  = OKAY;
    @(posedge clk);
    req_valid[n] <= 1'b1;
    req_write[n] <= wr;
    req_addr[n]  <= addr;
    req_wdata[n] <= wdata;
    do begin
      @(posedge clk);
    end while (!req_ready[n]);
    req_valid[n] <= 1'b0;
    while (!rsp_valid[n] && lat < RSP_LIMIT) begin
      @(posedge clk);
      lat++;
    end
    if (rsp_valid[n]) begin
      rdata = rsp_rdata[n];
      code  = rsp_code[n];
    end else begin
      errors++;
      $display("no response from initiator %0d within %0d cycles of acceptance", n, RSP_LIMIT);
    end
  endtask

  task automatic random_ops(input int n);
    logic [`NOC_DATA_W-1:0] rdata;
    noc_resp_e              code;
    int                     lat;
    for (int k = 0; k < RAND_OPS; k++) begin
      do_access(n, rnd_wr[n][k], rnd_addr[n][k], rnd_data[n][k], rdata, code, lat);
    end
  endtask

  task automatic end_test(input int num, input string name);
    int fails;
    @(posedge clk); // let the checker finish the last sample.
    fails = total_errors() - test_base;
    if (fails == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    $display("test %0d %s: %s", num, name, (fails == 0) ? "pass" : "fail");
    test_base = total_errors();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [`NOC_DATA_W-1:0] rdata;
    logic [`NOC_DATA_W-1:0] wdata;
    logic [31:0]            rnd;
    noc_resp_e              code;
    int                     lat;

    seed      = 32'ha1a7;
    errors    = 0;
    test_base = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    rst       = 1'b1;
    req_valid = '0;
    req_write = '0;
    req_addr  = '0;
    req_wdata = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    repeat (4) begin
      @(posedge clk);
      for (int n = 0; n < 2; n++) begin
        check_word($sformatf("o_req%0d_ready", n), req_ready[n], 1'b1);
        check_word($sformatf("o_rsp%0d_valid", n), rsp_valid[n], 1'b0);
      end
    end
    end_test(1, "reset state");

    wdata = $random(seed);
    do_access(0, 1'b1, word_addr(2'd0, 8'd5), wdata, rdata, code, lat);
    check_word("o_rsp0_code", code, OKAY);
    do_access(0, 1'b0, word_addr(2'd0, 8'd5), '0, rdata, code, lat);
    check_word("o_rsp0_code", code, OKAY);
    check_word("o_rsp0_rdata", rdata, wdata);
    end_test(2, "write then read on initiator 0");

    for (int i = 0; i < 4; i++) begin
      exp_tgt0[i] = $random(seed);
      exp_tgt1[i] = ~exp_tgt0[i]; // same index, every bit differs.
      do_access(0, 1'b1, word_addr(2'd0, i), exp_tgt0[i], rdata, code, lat);
      do_access(0, 1'b1, word_addr(2'd1, i), exp_tgt1[i], rdata, code, lat);
    end
    for (int i = 0; i < 4; i++) begin
      do_access(1, 1'b0, word_addr(2'd0, i), '0, rdata, code, lat);
      check_word("o_rsp1_code", code, OKAY);
      check_word("o_rsp1_rdata", rdata, exp_tgt0[i]);
      do_access(1, 1'b0, word_addr(2'd1, i), '0, rdata, code, lat);
      check_word("o_rsp1_code", code, OKAY);
      check_word("o_rsp1_rdata", rdata, exp_tgt1[i]);
    end
    end_test(3, "cross reads of both targets");

    wdata = $random(seed);
    do_access(0, 1'b1, word_addr(2'd2, 8'd1), wdata, rdata, code, lat);
    check_word("o_rsp0_code", code, DECERR);
    check_word("o_rsp0_rdata", rdata, '0);
    check_word("o_rsp0_valid latency", lat, 1);
    do_access(1, 1'b0, word_addr(2'd3, 8'd1), '0, rdata, code, lat);
    check_word("o_rsp1_code", code, DECERR);
    check_word("o_rsp1_rdata", rdata, '0);
    check_word("o_rsp1_valid latency", lat, 1);
    do_access(0, 1'b0, word_addr(2'd0, 8'd1), '0, rdata, code, lat);
    check_word("o_rsp0_rdata", rdata, exp_tgt0[1]);
    do_access(1, 1'b0, word_addr(2'd1, 8'd1), '0, rdata, code, lat);
    check_word("o_rsp1_rdata", rdata, exp_tgt1[1]);
    end_test(4, "decode error");

    // words 0 to 3 of both targets are known, so every mapped read can be checked.
    for (int k = 0; k < RAND_OPS; k++) begin
      for (int n = 0; n < 2; n++) begin
        rnd            = $random(seed);
        rnd_wr[n][k]   = rnd[0];
        rnd_addr[n][k] = word_addr(rnd[2:1], {6'b0, rnd[4:3]});
        rnd_data[n][k] = $random(seed);
      end
    end
    fork
      random_ops(0);
      random_ops(1);
    join
    end_test(5, "random traffic from both initiators");

    @(posedge clk);
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && total_errors() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/noc_access_pkg.sv
package noc_access_pkg;

  // AXI style codes, only two of them are produced here.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } noc_resp_e;

  // top two address bits select the target.
  // the word inside a target is taken from the bits above the byte offset.
  typedef enum logic [1:0] {
    NOC_REGION_TGT0  = 2'd0,
    NOC_REGION_TGT1  = 2'd1,
    NOC_REGION_NONE2 = 2'd2,
    NOC_REGION_NONE3 = 2'd3
  } noc_region_e;

endpackage

// File: hdl/noc_flit_arbiter.sv
`timescale 1ns/1ps

module noc_flit_arbiter (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic [1:0]               i_valid,
  input  logic [1:0]               i_last,
  input  noc_flit_pkg::noc_flit_u  i_flit [2],
  output logic [1:0]               o_ready,
  output logic                     o_valid,
  output logic                     o_last,
  output noc_flit_pkg::noc_flit_u  o_flit,
  input  logic [1:0]               i_ready
);
  logic rr_ptr;     // port that wins when both ask.
  logic lock;
  logic grant_q;
  logic grant;
  logic sink_ready;
  logic xfer;

  // a flit is taken if any sink on the merged bus takes it.
  assign sink_ready = |i_ready;

  always_comb begin
    if (lock) begin
      grant = grant_q;
    end else if (i_valid[rr_ptr]) begin
      grant = rr_ptr;
    end else if (i_valid[~rr_ptr]) begin
      grant = ~rr_ptr;
    end else begin
      grant = rr_ptr;
    end
  end

  assign o_valid = i_valid[grant];
  assign o_last  = i_last[grant];
  assign o_flit  = i_flit[grant];
  assign o_ready = grant ? {sink_ready, 1'b0} : {1'b0, sink_ready};
  assign xfer    = o_valid && sink_ready;

  // the grant is also held for a stalled flit, which keeps the merged bus stable.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rr_ptr  <= 1'b0;
      lock    <= 1'b0;
      grant_q <= 1'b0;
    end else if (o_valid) begin
      if (xfer && o_last) begin
        lock   <= 1'b0;
        rr_ptr <= ~grant; // other port first next time.
      end else begin
        lock    <= 1'b1;
        grant_q <= grant;
      end
    end
  end

endmodule

// File: hdl/noc_flit_pkg.sv
`include "noc_macros.svh"

package noc_flit_pkg;

  typedef enum logic [1:0] {
    READ_REQ  = 2'd0,
    WRITE_REQ = 2'd1,
    READ_RSP  = 2'd2,
    WRITE_RSP = 2'd3
  } noc_flit_kind_e;

  // first flit of every packet.
  typedef struct packed {
    noc_flit_kind_e                       kind;
    logic [1:0]                           src_id;
    logic [1:0]                           dst_id;
    logic [1:0]                           resp;     // response code, zero in requests.
    logic [`NOC_ADDR_W-1:0]               address;
    logic [`NOC_DATA_W-`NOC_ADDR_W-9:0]   reserved;
  } noc_flit_header_t;

  // second flit, present for writes and read responses.
  typedef struct packed {
    logic [`NOC_DATA_W-1:0] data;
  } noc_flit_payload_t;

  // the same bus word, read as header or payload by its position in the packet.
  typedef union packed {
    noc_flit_header_t   header;
    noc_flit_payload_t  payload;
  } noc_flit_u;

endpackage

// File: hdl/noc_initiator_adapter.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_initiator_adapter #(
  parameter logic [1:0] NODE_ID = `NOC_ID_INIT0
)(
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_req_valid,
  input  logic                       i_req_write,
  input  logic [`NOC_ADDR_W-1:0]     i_req_addr,
  input  logic [`NOC_DATA_W-1:0]     i_req_wdata,
  output logic                       o_req_ready,
  output logic                       o_flit_valid,
  output logic                       o_flit_last,
  output noc_flit_pkg::noc_flit_u    o_flit,
  input  logic                       i_flit_ready,
  input  logic                       i_rsp_flit_valid,
  input  logic                       i_rsp_flit_last,
  input  noc_flit_pkg::noc_flit_u    i_rsp_flit,
  output logic                       o_rsp_valid,
  output logic [`NOC_DATA_W-1:0]     o_rsp_rdata,
  output noc_access_pkg::noc_resp_e  o_rsp_code
);
  import noc_flit_pkg::*;
  import noc_access_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HDR,
    ST_DATA,
    ST_WAIT,
    ST_DONE
  } state_e;

  state_e                 state;
  logic                   req_xfer;
  noc_region_e            region;
  logic                   dec_err;
  logic [1:0]             dst_id;
  logic [1:0]             tgt_id;
  logic                   wr_op;
  logic [`NOC_ADDR_W-1:0] addr;
  logic [`NOC_DATA_W-1:0] wdata;
  logic                   rsp_mid;  // next response flit on the bus is a payload.
  logic                   rsp_own;  // and that payload is ours.
  logic                   rsp_hdr_hit;
  logic                   rsp_dat_hit;

  assign region = noc_region_e'(i_req_addr[`NOC_ADDR_W-1 -: 2]);

  always_comb begin
    dec_err = 1'b0;
    dst_id  = `NOC_ID_TGT0;
    case (region)
      NOC_REGION_TGT0: dst_id = `NOC_ID_TGT0;
      NOC_REGION_TGT1: dst_id = `NOC_ID_TGT1;
      default:         dec_err = 1'b1; // unmapped space.
    endcase
  end

  assign o_req_ready  = (state == ST_IDLE);
  assign req_xfer     = i_req_valid && o_req_ready;
  assign o_flit_valid = (state == ST_HDR) || (state == ST_DATA);
  assign o_flit_last  = (state == ST_DATA) || ((state == ST_HDR) && !wr_op);
  assign o_rsp_valid  = (state == ST_DONE);

  always_comb begin
    o_flit = '0;
    if (state == ST_DATA) begin
      o_flit.payload.data = wdata;
    end else begin
      o_flit.header.kind    = wr_op ? WRITE_REQ : READ_REQ;
      o_flit.header.src_id  = NODE_ID;
      o_flit.header.dst_id  = tgt_id;
      o_flit.header.address = addr;
    end
  end

  // every flit on the response bus is taken, so the packet boundary is known exactly.
  assign rsp_hdr_hit = i_rsp_flit_valid && !rsp_mid && (i_rsp_flit.header.dst_id == NODE_ID);
  assign rsp_dat_hit = i_rsp_flit_valid && rsp_own;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= ST_IDLE;
      rsp_mid <= 1'b0;
      rsp_own <= 1'b0;
    end else begin
      if (i_rsp_flit_valid) begin
        rsp_mid <= !i_rsp_flit_last;
        rsp_own <= rsp_hdr_hit && !i_rsp_flit_last;
      end
      case (state)
        ST_IDLE: begin
          if (req_xfer) begin
            state <= dec_err ? ST_DONE : ST_HDR;
          end
        end
        ST_HDR: begin
          if (i_flit_ready) begin
            state <= wr_op ? ST_DATA : ST_WAIT;
          end
        end
        ST_DATA: begin
          if (i_flit_ready) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if ((rsp_hdr_hit && i_rsp_flit_last) || rsp_dat_hit) begin
            state <= ST_DONE;
          end
        end
        default: state <= ST_IDLE; // ST_DONE lasts one cycle.
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_xfer) begin
      wr_op  <= i_req_write;
      addr   <= i_req_addr;
      wdata  <= i_req_wdata;
      tgt_id <= dst_id;
    end
    if (req_xfer && dec_err) begin
      o_rsp_code  <= DECERR;
      o_rsp_rdata <= '0;
    end
    if ((state == ST_WAIT) && rsp_hdr_hit) begin
      o_rsp_code  <= noc_resp_e'(i_rsp_flit.header.resp);
      o_rsp_rdata <= '0;
    end
    if ((state == ST_WAIT) && rsp_dat_hit) begin
      o_rsp_rdata <= i_rsp_flit.payload.data;
    end
  end

endmodule

// File: hdl/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// word and address widths of the access side.
`define NOC_DATA_W    32
`define NOC_ADDR_W    16

`define NOC_MEM_DEPTH 256 // words in each target memory.

// node ids on the flit buses.
`define NOC_ID_INIT0  2'd0
`define NOC_ID_INIT1  2'd1
`define NOC_ID_TGT0   2'd2
`define NOC_ID_TGT1   2'd3

`endif

// File: hdl/noc_subsys_top.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_subsys_top (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_req0_valid,
  input  logic                       i_req0_write,
  input  logic [`NOC_ADDR_W-1:0]     i_req0_addr,
  input  logic [`NOC_DATA_W-1:0]     i_req0_wdata,
  output logic                       o_req0_ready,
  output logic                       o_rsp0_valid,
  output logic [`NOC_DATA_W-1:0]     o_rsp0_rdata,
  output noc_access_pkg::noc_resp_e  o_rsp0_code,
  input  logic                       i_req1_valid,
  input  logic                       i_req1_write,
  input  logic [`NOC_ADDR_W-1:0]     i_req1_addr,
  input  logic [`NOC_DATA_W-1:0]     i_req1_wdata,
  output logic                       o_req1_ready,
  output logic                       o_rsp1_valid,
  output logic [`NOC_DATA_W-1:0]     o_rsp1_rdata,
  output noc_access_pkg::noc_resp_e  o_rsp1_code
);
  import noc_flit_pkg::*;

  // initiator side of the request arbiter.
  logic [1:0] init_valid;
  logic [1:0] init_last;
  noc_flit_u  init_flit [2];
  logic [1:0] init_ready;

  // merged request bus.
  logic       req_valid;
  logic       req_last;
  noc_flit_u  req_flit;
  logic [1:0] tgt_req_ready;

  // target side of the response arbiter.
  logic [1:0] tgt_valid;
  logic [1:0] tgt_last;
  noc_flit_u  tgt_flit [2];
  logic [1:0] tgt_ready;

  // merged response bus.
  logic       rsp_valid;
  logic       rsp_last;
  noc_flit_u  rsp_flit;

  noc_initiator_adapter #(
    .NODE_ID  (`NOC_ID_INIT0)
  ) u_init0 (
    .i_clk            (i_clk          ),
    .i_rst            (i_rst          ),
    .i_req_valid      (i_req0_valid   ),
    .i_req_write      (i_req0_write   ),
    .i_req_addr       (i_req0_addr    ),
    .i_req_wdata      (i_req0_wdata   ),
    .o_req_ready      (o_req0_ready   ),
    .o_flit_valid     (init_valid[0]  ),
    .o_flit_last      (init_last[0]   ),
    .o_flit           (init_flit[0]   ),
    .i_flit_ready     (init_ready[0]  ),
    .i_rsp_flit_valid (rsp_valid      ),
    .i_rsp_flit_last  (rsp_last       ),
    .i_rsp_flit       (rsp_flit       ),
    .o_rsp_valid      (o_rsp0_valid   ),
    .o_rsp_rdata      (o_rsp0_rdata   ),
    .o_rsp_code       (o_rsp0_code    )
  );

  noc_initiator_adapter #(
    .NODE_ID  (`NOC_ID_INIT1)
  ) u_init1 (
    .i_clk            (i_clk          ),
    .i_rst            (i_rst          ),
    .i_req_valid      (i_req1_valid   ),
    .i_req_write      (i_req1_write   ),
    .i_req_addr       (i_req1_addr    ),
    .i_req_wdata      (i_req1_wdata   ),
    .o_req_ready      (o_req1_ready   ),
    .o_flit_valid     (init_valid[1]  ),
    .o_flit_last      (init_last[1]   ),
    .o_flit           (init_flit[1]   ),
    .i_flit_ready     (init_ready[1]  ),
    .i_rsp_flit_valid (rsp_valid      ),
    .i_rsp_flit_last  (rsp_last       ),
    .i_rsp_flit       (rsp_flit       ),
    .o_rsp_valid      (o_rsp1_valid   ),
    .o_rsp_rdata      (o_rsp1_rdata   ),
    .o_rsp_code       (o_rsp1_code    )
  );

  noc_flit_arbiter u_req_arb (
    .i_clk    (i_clk          ),
    .i_rst    (i_rst          ),
    .i_valid  (init_valid     ),
    .i_last   (init_last      ),
    .i_flit   (init_flit      ),
    .o_ready  (init_ready     ),
    .o_valid  (req_valid      ),
    .o_last   (req_last       ),
    .o_flit   (req_flit       ),
    .i_ready  (tgt_req_ready  )
  );

  noc_target_adapter #(
    .NODE_ID  (`NOC_ID_TGT0)
  ) u_tgt0 (
    .i_clk            (i_clk            ),
    .i_rst            (i_rst            ),
    .i_flit_valid     (req_valid        ),
    .i_flit_last      (req_last         ),
    .i_flit           (req_flit         ),
    .o_flit_ready     (tgt_req_ready[0] ),
    .o_rsp_flit_valid (tgt_valid[0]     ),
    .o_rsp_flit_last  (tgt_last[0]      ),
    .o_rsp_flit       (tgt_flit[0]      ),
    .i_rsp_flit_ready (tgt_ready[0]     )
  );

  noc_target_adapter #(
    .NODE_ID  (`NOC_ID_TGT1)
  ) u_tgt1 (
    .i_clk            (i_clk            ),
    .i_rst            (i_rst            ),
    .i_flit_valid     (req_valid        ),
    .i_flit_last      (req_last         ),
    .i_flit           (req_flit         ),
    .o_flit_ready     (tgt_req_ready[1] ),
    .o_rsp_flit_valid (tgt_valid[1]     ),
    .o_rsp_flit_last  (tgt_last[1]      ),
    .o_rsp_flit       (tgt_flit[1]      ),
    .i_rsp_flit_ready (tgt_ready[1]     )
  );

  // initiators never stall a response.
  noc_flit_arbiter u_rsp_arb (
    .i_clk    (i_clk      ),
    .i_rst    (i_rst      ),
    .i_valid  (tgt_valid  ),
    .i_last   (tgt_last   ),
    .i_flit   (tgt_flit   ),
    .o_ready  (tgt_ready  ),
    .o_valid  (rsp_valid  ),
    .o_last   (rsp_last   ),
    .o_flit   (rsp_flit   ),
    .i_ready  (2'b11      )
  );

endmodule

// File: hdl/noc_target_adapter.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_target_adapter #(
  parameter logic [1:0] NODE_ID = `NOC_ID_TGT0
)(
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_flit_valid,
  input  logic                     i_flit_last,
  input  noc_flit_pkg::noc_flit_u  i_flit,
  output logic                     o_flit_ready,
  output logic                     o_rsp_flit_valid,
  output logic                     o_rsp_flit_last,
  output noc_flit_pkg::noc_flit_u  o_rsp_flit,
  input  logic                     i_rsp_flit_ready
);
  import noc_flit_pkg::*;
  import noc_access_pkg::*;

  localparam int IDX_W = $clog2(`NOC_MEM_DEPTH);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WDATA,
    ST_RSP_HDR,
    ST_RSP_DATA
  } state_e;

  state_e                 state;
  logic                   skip;       // bus carries the payload of a packet for the other target.
  logic                   hdr_phase;
  logic                   claim;
  logic                   req_xfer;
  logic [1:0]             src_id;
  logic [`NOC_ADDR_W-1:0] addr;
  logic                   rd_op;
  logic [`NOC_DATA_W-1:0] rdata;
  logic [`NOC_DATA_W-1:0] mem [`NOC_MEM_DEPTH];

  assign hdr_phase    = !skip && (state != ST_WDATA);
  assign claim        = i_flit_valid && hdr_phase && (i_flit.header.dst_id == NODE_ID);
  assign o_flit_ready = (claim && (state == ST_IDLE)) || (state == ST_WDATA);
  assign req_xfer     = i_flit_valid && o_flit_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ST_IDLE;
      skip  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_xfer) begin
            state <= i_flit_last ? ST_RSP_HDR : ST_WDATA;
          end
        end
        ST_WDATA: begin
          if (req_xfer) begin
            state <= ST_RSP_HDR;
          end
        end
        ST_RSP_HDR: begin
          if (i_rsp_flit_ready) begin
            state <= rd_op ? ST_RSP_DATA : ST_IDLE;
          end
        end
        default: begin
          if (i_rsp_flit_ready) begin
            state <= ST_IDLE;
          end
        end
      endcase
      // the owner takes a payload at once, so a last flit seen here ends that packet.
      if (skip) begin
        if (i_flit_valid && i_flit_last) begin
          skip <= 1'b0;
        end
      end else if (i_flit_valid && hdr_phase && !i_flit_last &&
                   (i_flit.header.dst_id != NODE_ID)) begin
        skip <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if ((state == ST_IDLE) && req_xfer) begin
      src_id <= i_flit.header.src_id;
      addr   <= i_flit.header.address;
      rd_op  <= (i_flit.header.kind == READ_REQ);
    end
    if ((state == ST_IDLE) && req_xfer && i_flit_last) begin
      rdata <= mem[i_flit.header.address[IDX_W+1:2]];
    end
    if ((state == ST_WDATA) && req_xfer) begin
      mem[addr[IDX_W+1:2]] <= i_flit.payload.data;
    end
  end

  assign o_rsp_flit_valid = (state == ST_RSP_HDR) || (state == ST_RSP_DATA);
  assign o_rsp_flit_last  = (state == ST_RSP_DATA) || ((state == ST_RSP_HDR) && !rd_op);

  always_comb begin
    o_rsp_flit = '0;
    if (state == ST_RSP_DATA) begin
      o_rsp_flit.payload.data = rdata;
    end else begin
      o_rsp_flit.header.kind    = rd_op ? READ_RSP : WRITE_RSP;
      o_rsp_flit.header.src_id  = NODE_ID;
      o_rsp_flit.header.dst_id  = src_id; // back to the requester.
      o_rsp_flit.header.resp    = OKAY;
      o_rsp_flit.header.address = addr;
    end
  end

endmodule

// File: noc_subsys_top.f
+incdir+hdl
hdl/noc_flit_pkg.sv
hdl/noc_access_pkg.sv
hdl/noc_flit_arbiter.sv
hdl/noc_initiator_adapter.sv
hdl/noc_target_adapter.sv
hdl/noc_subsys_top.sv
dv/noc_clk_gen.sv
dv/noc_subsys_chk.sv
dv/noc_subsys_tb.sv
